/* design/eeprom_pkg.sv */
package eeprom_pkg;

    // fixed high nibble of the control byte
    localparam logic [3:0] DEV_CODE = 4'b1010;
    localparam int ADDR_W = 11;

    localparam logic [7:0] REG_CTRL   = 8'h00;   // bit 0 start, bit 1 read
    localparam logic [7:0] REG_ADDR   = 8'h04;
    localparam logic [7:0] REG_WDATA  = 8'h08;
    localparam logic [7:0] REG_STATUS = 8'h0C;   // bit 0 busy, bit 1 done, bit 2 nack
    localparam logic [7:0] REG_RDATA  = 8'h10;

    typedef struct packed {
        logic              go;
        logic              rd;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } xfer_cmd_t;

    typedef struct packed {
        logic       busy;
        logic       done;
        logic       nack;
        logic [7:0] rdata;
    } xfer_stat_t;

    typedef enum logic [2:0] {
        OP_START,
        OP_RESTART,
        OP_STOP,
        OP_WRITE,
        OP_READ_ACK,
        OP_READ_NACK
    } byte_op_e;

    typedef struct packed {
        logic       valid;
        byte_op_e   op;
        logic [7:0] tx;
    } byte_req_t;

    typedef struct packed {
        logic       done;
        logic       ack;   // slave pulled the ninth bit low
        logic [7:0] rx;
    } byte_rsp_t;

endpackage

/* design/eeprom_regs.sv */
module eeprom_regs (
    input  logic                   CLK,
    input  logic                   RESET,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pslverr,
    output eeprom_pkg::xfer_cmd_t  cmd,
    input  eeprom_pkg::xfer_stat_t stat
);
    import eeprom_pkg::*;

    logic              access;
    logic              mapped;
    logic              busy;
    logic              start_ok;
    logic              go_q;
    logic              rd_q;
    logic              done_q;
    logic              nack_q;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        wdata_q;
    logic [7:0]        rdata_q;

    assign access = psel && penable;

    // a go already in flight counts as busy
    assign busy = stat.busy || go_q;
    assign start_ok = access && pwrite && (paddr == REG_CTRL) && pwdata[0] && !busy;

    always_comb
    begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            REG_CTRL:   prdata = {30'd0, rd_q, 1'b0};
            REG_ADDR:   prdata = {{(32 - ADDR_W){1'b0}}, addr_q};
            REG_WDATA:  prdata = {24'd0, wdata_q};
            REG_STATUS: prdata = {29'd0, nack_q, done_q, stat.busy};
            REG_RDATA:  prdata = {24'd0, rdata_q};
            default:    mapped = 1'b0;
        endcase
    end

    assign pslverr = access && !mapped;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            go_q   <= 1'b0;
            rd_q   <= 1'b0;
            done_q <= 1'b0;
            nack_q <= 1'b0;
        end
        else
        begin
            go_q <= start_ok;
            if (start_ok)
            begin
                rd_q   <= pwdata[1];
                done_q <= 1'b0;
                nack_q <= 1'b0;
            end
            else if (stat.done)
            begin
                done_q <= 1'b1;   // sticky until next start
                nack_q <= stat.nack;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (access && pwrite && (paddr == REG_ADDR))
            addr_q <= pwdata[ADDR_W-1:0];
        if (access && pwrite && (paddr == REG_WDATA))
            wdata_q <= pwdata[7:0];
        if (stat.done && !stat.nack)
            rdata_q <= stat.rdata;   // failed read keeps old value
    end

    assign cmd = '{go: go_q, rd: rd_q, addr: addr_q, wdata: wdata_q};

endmodule

/* design/eeprom_sequencer.sv */
module eeprom_sequencer (
    input  logic                   CLK,
    input  logic                   RESET,
    input  eeprom_pkg::xfer_cmd_t  cmd,
    output eeprom_pkg::xfer_stat_t stat,
    output eeprom_pkg::byte_req_t  req,
    input  eeprom_pkg::byte_rsp_t  rsp
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_CTRL_W,
        S_ADDR,
        S_DATA,
        S_RESTART,
        S_CTRL_R,
        S_READ,
        S_STOP
    } seq_state_e;

    seq_state_e        state;
    byte_op_e          op;
    logic [7:0]        tx;
    logic [7:0]        ctrl_w;
    logic [7:0]        ctrl_r;
    logic              rd_q;
    logic              nack_q;
    logic [ADDR_W-1:0] addr_q;
    logic [7:0]        wdata_q;
    logic [7:0]        rdata_q;

    // block bits ride in the control byte
    assign ctrl_w = {DEV_CODE, addr_q[ADDR_W-1:8], 1'b0};
    assign ctrl_r = {DEV_CODE, addr_q[ADDR_W-1:8], 1'b1};

    always_comb
    begin
        op = OP_WRITE;
        tx = 8'h00;
        case (state)
            S_START:   op = OP_START;
            S_CTRL_W:  tx = ctrl_w;
            S_ADDR:    tx = addr_q[7:0];
            S_DATA:    tx = wdata_q;
            S_RESTART: op = OP_RESTART;
            S_CTRL_R:  tx = ctrl_r;
            S_READ:    op = OP_READ_NACK;   // single byte, nack ends the read
            default:   op = OP_STOP;
        endcase
    end

    assign req  = '{valid: state != S_IDLE, op: op, tx: tx};
    assign stat = '{busy: state != S_IDLE, done: (state == S_STOP) && rsp.done,
                    nack: nack_q, rdata: rdata_q};

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state  <= S_IDLE;
            nack_q <= 1'b0;
        end
        else if (state == S_IDLE)
        begin
            if (cmd.go)
            begin
                nack_q <= 1'b0;
                state  <= S_START;
            end
        end
        else if (rsp.done)
        begin
            if ((op == OP_WRITE) && !rsp.ack)
            begin
                nack_q <= 1'b1;   // abort with stop
                state  <= S_STOP;
            end
            else
            begin
                case (state)
                    S_START:   state <= S_CTRL_W;
                    S_CTRL_W:  state <= S_ADDR;
                    S_ADDR:    state <= rd_q ? S_RESTART : S_DATA;
                    S_DATA:    state <= S_STOP;
                    S_RESTART: state <= S_CTRL_R;
                    S_CTRL_R:  state <= S_READ;
                    S_READ:    state <= S_STOP;
                    default:   state <= S_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if ((state == S_IDLE) && cmd.go)
        begin
            rd_q    <= cmd.rd;
            addr_q  <= cmd.addr;
            wdata_q <= cmd.wdata;
        end
        if ((state == S_READ) && rsp.done)
            rdata_q <= rsp.rx;
    end

endmodule

/* design/i2c_byte_engine.sv */
module i2c_byte_engine #(
    parameter int CLK_DIV = 4
) (
    input  logic                  CLK,
    input  logic                  RESET,
    input  eeprom_pkg::byte_req_t req,
    output eeprom_pkg::byte_rsp_t rsp,
    output logic                  scl,
    output logic                  sda_oe,
    input  logic                  sda_in
);
    import eeprom_pkg::*;

    localparam int CNT_W = $clog2(CLK_DIV);
    // sda moves here, clear of both scl edges
    localparam int MID = CLK_DIV / 2 - 1;

    logic             active;
    logic             done_q;
    logic             ack_q;
    logic             scl_q;
    logic             oe_q;
    logic [CNT_W-1:0] cnt;
    logic [4:0]       hp;       // half-period index within the op
    logic [3:0]       bit_idx;
    logic             accept;
    logic             tick;
    logic             at_mid;
    logic             byte_op;
    logic             byte_drive;
    byte_op_e         op_q;
    logic [7:0]       sh;

    function automatic logic [4:0] last_half(byte_op_e op);
        case (op)
            OP_START, OP_STOP: last_half = 5'd1;
            OP_RESTART:        last_half = 5'd2;
            default:           last_half = 5'd17;   // 8 data bits plus ack
        endcase
    endfunction

    function automatic logic scl_level(byte_op_e op, logic [4:0] h);
        case (op)
            OP_START:            scl_level = (h == 5'd0);
            OP_RESTART, OP_STOP: scl_level = (h == 5'd1);
            default:             scl_level = h[0];  // low half then high half per bit
        endcase
    endfunction

    assign accept  = !active && req.valid && !done_q;
    assign tick    = (cnt == CNT_W'(CLK_DIV - 1));
    assign at_mid  = active && (cnt == CNT_W'(MID));
    assign bit_idx = hp[4:1];
    assign byte_op = (op_q == OP_WRITE) || (op_q == OP_READ_ACK) || (op_q == OP_READ_NACK);

    // ack slot: drive low only for a read that wants more
    assign byte_drive = (bit_idx == 4'd8) ? (op_q == OP_READ_ACK)
                                          : ((op_q == OP_WRITE) && !sh[7]);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active <= 1'b0;
            done_q <= 1'b0;
            ack_q  <= 1'b0;
            cnt    <= '0;
            hp     <= '0;
            scl_q  <= 1'b1;
            oe_q   <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (accept)
            begin
                active <= 1'b1;
                ack_q  <= 1'b0;
                cnt    <= '0;
                hp     <= '0;
                scl_q  <= scl_level(req.op, 5'd0);
            end
            else if (active)
            begin
                cnt <= tick ? '0 : cnt + 1'b1;
                if (at_mid)
                begin
                    case (op_q)
                        OP_START:   oe_q <= 1'b1;             // falls while scl high
                        OP_RESTART: oe_q <= (hp != 5'd0);     // release, then start edge
                        OP_STOP:    oe_q <= (hp == 5'd0);     // low, then rise as stop
                        default:
                        begin
                            if (!hp[0])
                                oe_q <= byte_drive;
                            else if ((bit_idx == 4'd8) && (op_q == OP_WRITE))
                                ack_q <= !sda_in;
                        end
                    endcase
                end
                if (tick)
                begin
                    if (hp == last_half(op_q))
                    begin
                        active <= 1'b0;
                        done_q <= 1'b1;
                    end
                    else
                    begin
                        hp    <= hp + 5'd1;
                        scl_q <= scl_level(op_q, hp + 5'd1);
                    end
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            op_q <= req.op;
            sh   <= req.tx;
        end
        else if (at_mid && byte_op && (bit_idx < 4'd8))
        begin
            if (!hp[0] && (op_q == OP_WRITE))
                sh <= {sh[6:0], 1'b0};   // msb first
            else if (hp[0] && (op_q != OP_WRITE))
                sh <= {sh[6:0], sda_in};
        end
    end

    assign rsp    = '{done: done_q, ack: ack_q, rx: sh};
    assign scl    = scl_q;
    assign sda_oe = oe_q;

endmodule

/* design/eeprom_ctrl_top.sv */
module eeprom_ctrl_top #(
    parameter int CLK_DIV = 4
) (
    input  logic        CLK,
    input  logic        RESET,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pslverr,
    output logic        scl,
    output logic        sda_oe,   // high pulls the line low
    input  logic        sda_in
);
    import eeprom_pkg::*;

    xfer_cmd_t  cmd;
    xfer_stat_t stat;
    byte_req_t  req;
    byte_rsp_t  rsp;

    eeprom_regs u_regs (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .cmd     (cmd),
        .stat    (stat)
    );

    eeprom_sequencer u_sequencer (
        .CLK   (CLK),
        .RESET (RESET),
        .cmd   (cmd),
        .stat  (stat),
        .req   (req),
        .rsp   (rsp)
    );

    i2c_byte_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_byte_engine (
        .CLK    (CLK),
        .RESET  (RESET),
        .req    (req),
        .rsp    (rsp),
        .scl    (scl),
        .sda_oe (sda_oe),
        .sda_in (sda_in)
    );

endmodule

/* tests/clk_gen.sv */
module clk_gen (
    output logic CLK,
    output logic RESET
);
    initial
    begin
        CLK   = 1'b0;
        RESET = 1'b1;
        repeat (16) @(posedge CLK);
        #2 RESET = 1'b0;
    end

    always #10 CLK = ~CLK;   // period 20

endmodule

/* tests/eeprom_model.sv */
module eeprom_model (
    input  logic CLK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    input  logic force_nack,
    output logic sda_pull
);
    import eeprom_pkg::*;

    typedef enum logic [2:0] {
        M_IDLE,
        M_RX,
        M_ACK,
        M_TX,
        M_MACK
    } model_state_e;

    model_state_e state;
    logic [7:0]   mem [0:2047];
    logic         scl_d;
    logic         sda_d;
    logic         acked;
    logic         ack_now;
    logic         rw;
    logic [2:0]   blk;
    logic [7:0]   addr_lo;
    logic [7:0]   sh;
    logic [3:0]   cnt;
    logic [1:0]   byte_idx;

    initial
    begin
        logic [ADDR_W-1:0] a;
        int                i;
        for (i = 0; i < 2048; i++)
        begin
            a      = ADDR_W'(i);
            mem[i] = {a[2:0], a[10:6]} ^ a[7:0];
        end
    end

    // control byte must carry the device code
    assign ack_now = !force_nack && ((byte_idx != 2'd0) || (sh[7:4] == DEV_CODE));

    always @(posedge CLK)
    begin
        scl_d <= scl;
        sda_d <= sda;
        if (RESET)
        begin
            state    <= M_IDLE;
            sda_pull <= 1'b0;
        end
        else if (scl && scl_d && sda_d && !sda)
        begin
            state    <= M_RX;   // start or repeated start
            cnt      <= 4'd0;
            byte_idx <= 2'd0;
            sda_pull <= 1'b0;
        end
        else if (scl && scl_d && !sda_d && sda)
        begin
            state    <= M_IDLE;   // stop
            sda_pull <= 1'b0;
        end
        else if (scl && !scl_d && (state == M_RX))
        begin
            sh  <= {sh[6:0], sda};
            cnt <= cnt + 4'd1;
        end
        else if (!scl && scl_d)
        begin
            case (state)
                M_RX:
                begin
                    if (cnt == 4'd8)
                    begin
                        state    <= M_ACK;
                        acked    <= ack_now;
                        sda_pull <= ack_now;
                        if (byte_idx == 2'd0)
                        begin
                            blk <= sh[3:1];
                            rw  <= sh[0];
                        end
                        else if (byte_idx == 2'd1)
                            addr_lo <= sh;
                        else if ((byte_idx == 2'd2) && ack_now)
                            mem[{blk, addr_lo}] <= sh;
                    end
                end
                M_ACK:
                begin
                    cnt      <= 4'd0;
                    sda_pull <= 1'b0;   // let go after the ack clock
                    if (!acked)
                        state <= M_IDLE;
                    else if ((byte_idx == 2'd0) && rw)
                    begin
                        state    <= M_TX;
                        sh       <= {mem[{blk, addr_lo}][6:0], 1'b0};
                        sda_pull <= !mem[{blk, addr_lo}][7];
                        cnt      <= 4'd1;
                    end
                    else
                    begin
                        state    <= M_RX;
                        byte_idx <= byte_idx + 2'd1;
                    end
                end
                M_TX:
                begin
                    cnt      <= cnt + 4'd1;
                    sda_pull <= (cnt == 4'd8) ? 1'b0 : !sh[7];
                    sh       <= {sh[6:0], 1'b0};
                    if (cnt == 4'd8)
                        state <= M_MACK;
                end
                M_MACK:
                    state <= M_IDLE;   // single byte reads only
                default:
                    state <= state;
            endcase
        end
    end

endmodule

/* tests/eeprom_ctrl_tb.sv */
module eeprom_ctrl_tb;
    import eeprom_pkg::*;

    localparam int CLK_DIV    = 4;
    localparam int WAIT_LIMIT = 5000;

    typedef struct packed {
        logic              rd;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        data;
        logic              fnack;
        logic [2:0]        exp_status;   // nack, done, busy
        logic [7:0]        exp_rdata;
    } xfer_entry_t;

    logic        CLK;
    logic        RESET;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pslverr;
    logic        scl;
    logic        sda_oe;
    logic        sda;
    logic        model_pull;
    logic        force_nack;
    logic [31:0] cycle_cnt;
    logic [7:0]  shadow [0:2047];
    logic [7:0]  last_rdata;
    xfer_entry_t table_q [$];

    clk_gen u_clk_gen (
        .CLK   (CLK),
        .RESET (RESET)
    );

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) u_eeprom_ctrl_top (
        .CLK     (CLK),
        .RESET   (RESET),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pslverr (pslverr),
        .scl     (scl),
        .sda_oe  (sda_oe),
        .sda_in  (sda)
    );

    eeprom_model u_eeprom_model (
        .CLK        (CLK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda),
        .force_nack (force_nack),
        .sda_pull   (model_pull)
    );

    assign sda = !(sda_oe || model_pull);   // wired-AND of both drivers

    always @(posedge CLK)
    begin
        if (RESET)
            cycle_cnt <= 32'd0;
        else
            cycle_cnt <= cycle_cnt + 32'd1;
    end

    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        fill_byte = {a[2:0], a[10:6]} ^ a[7:0];
    endfunction

    // expected result of one transfer and the shadow update
    function automatic xfer_entry_t plan_entry(input logic rd, input logic [ADDR_W-1:0] addr,
                                               input logic [7:0] data, input logic fnack);
        xfer_entry_t e;
        e.rd         = rd;
        e.addr       = addr;
        e.data       = data;
        e.fnack      = fnack;
        e.exp_status = {fnack, 1'b1, 1'b0};
        if (!rd && !fnack)
            shadow[addr] = data;
        if (rd && !fnack)
            last_rdata = shadow[addr];
        e.exp_rdata  = last_rdata;
        plan_entry   = e;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        assert (got === exp)
        else
            stop_on_error($sformatf("Fail %0t: %s got 0x%0h expected 0x%0h",
                                    $time, what, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge CLK);
        #2;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic err);
        psel   = 1'b1;
        pwrite = 1'b1;
        paddr  = addr;
        pwdata = data;
        next_cycle();
        penable = 1'b1;
        @(negedge CLK);
        err = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        psel   = 1'b1;
        pwrite = 1'b0;
        paddr  = addr;
        next_cycle();
        penable = 1'b1;
        @(negedge CLK);
        data = prdata;
        err  = pslverr;
        next_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_reset();
        int n;
        n = 0;
        @(negedge CLK);
        while (RESET)
        begin
            n = n + 1;
            if (n > 100)
                stop_on_error("timeout waiting for reset to be released");
            @(negedge CLK);
        end
        next_cycle();
    endtask

    task automatic wait_done(output logic [31:0] st);
        logic [31:0] start;
        logic        err;
        start = cycle_cnt;
        apb_read(REG_STATUS, st, err);
        while (!st[1])
        begin
            if ((cycle_cnt - start) > WAIT_LIMIT)
                stop_on_error("timeout waiting for the transfer done bit in status");
            apb_read(REG_STATUS, st, err);
        end
    endtask

    task automatic run_entry(input xfer_entry_t e);
        logic [31:0] st;
        logic [31:0] rd;
        logic        err;
        force_nack = e.fnack;
        apb_write(REG_ADDR, {21'd0, e.addr}, err);
        apb_write(REG_WDATA, {24'd0, e.data}, err);
        apb_write(REG_CTRL, {30'd0, e.rd, 1'b1}, err);
        wait_done(st);
        check_value(st, {29'd0, e.exp_status}, $sformatf("status at addr 0x%0h", e.addr));
        if (e.rd)
        begin
            apb_read(REG_RDATA, rd, err);
            check_value(rd, {24'd0, e.exp_rdata}, $sformatf("read data at 0x%0h", e.addr));
        end
        force_nack = 1'b0;
    endtask

    initial
    begin
        logic [31:0]       st;
        logic [31:0]       v;
        logic              err;
        logic [ADDR_W-1:0] a;
        logic [7:0]        d;
        logic [7:0]        low;
        xfer_entry_t       e;
        int                i;

        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 8'h00;
        pwdata     = 32'h0;
        force_nack = 1'b0;
        last_rdata = 8'h00;
        void'($urandom(32'hf018_553c));
        for (i = 0; i < 2048; i++)
            shadow[i] = fill_byte(ADDR_W'(i));

        a   = ADDR_W'($urandom());
        d   = 8'($urandom()) | 8'h80;   // kept apart from the block bytes below
        low = 8'($urandom());
        table_q.push_back(plan_entry(1'b0, a, d, 1'b0));
        table_q.push_back(plan_entry(1'b1, a, 8'h00, 1'b0));
        table_q.push_back(plan_entry(1'b0, {3'd1, low}, 8'h11, 1'b0));
        table_q.push_back(plan_entry(1'b0, {3'd5, low}, 8'h5A, 1'b0));
        table_q.push_back(plan_entry(1'b0, {3'd6, low}, 8'h3C, 1'b0));
        table_q.push_back(plan_entry(1'b1, {3'd1, low}, 8'h00, 1'b0));
        table_q.push_back(plan_entry(1'b1, {3'd5, low}, 8'h00, 1'b0));
        table_q.push_back(plan_entry(1'b1, {3'd6, low}, 8'h00, 1'b0));
        table_q.push_back(plan_entry(1'b0, a, ~d, 1'b1));
        table_q.push_back(plan_entry(1'b1, a, 8'h00, 1'b0));
        table_q.push_back(plan_entry(1'b1, {3'd5, low}, 8'h00, 1'b1));
        for (i = 0; i < 6; i++)
        begin
            a = ADDR_W'($urandom());
            d = 8'($urandom());
            table_q.push_back(plan_entry(1'b0, a, d, 1'b0));
            table_q.push_back(plan_entry(1'b1, a, 8'h00, 1'b0));
        end
        for (i = 0; i < 2; i++)
            table_q.push_back(plan_entry(1'b1, ADDR_W'($urandom()), 8'h00, 1'b0));

        wait_reset();
        @(negedge CLK);
        check_value({31'd0, scl}, 32'd1, "scl after reset");
        check_value({31'd0, sda_oe}, 32'd0, "sda_oe after reset");
        next_cycle();
        apb_read(REG_STATUS, st, err);
        check_value(st, 32'd0, "status after reset");

        for (i = 0; i < table_q.size(); i++)
            run_entry(table_q[i]);

        // second start while busy
        a = ADDR_W'($urandom());
        d = 8'($urandom());
        e = plan_entry(1'b0, a, d, 1'b0);
        apb_write(REG_ADDR, {21'd0, a}, err);
        apb_write(REG_WDATA, {24'd0, d}, err);
        apb_write(REG_CTRL, 32'h1, err);
        apb_read(REG_STATUS, st, err);
        check_value({31'd0, st[0]}, 32'd1, "busy after start");
        apb_write(REG_CTRL, 32'h3, err);
        wait_done(st);
        check_value(st, {29'd0, e.exp_status}, "status after double start");
        apb_read(REG_CTRL, v, err);
        check_value(v, 32'd0, "ctrl read bit after double start");
        repeat (100) next_cycle();
        apb_read(REG_STATUS, st, err);
        check_value(st, {29'd0, e.exp_status}, "status well after double start");
        run_entry(plan_entry(1'b1, a, 8'h00, 1'b0));

        // unmapped offsets
        apb_write(8'h14, 32'hFFFF_FFFF, err);
        check_value({31'd0, err}, 32'd1, "pslverr on write to 0x14");
        apb_write(8'h01, 32'h0000_0001, err);
        check_value({31'd0, err}, 32'd1, "pslverr on write to 0x01");
        apb_read(8'h14, v, err);
        check_value({31'd0, err}, 32'd1, "pslverr on read of 0x14");
        apb_read(REG_ADDR, v, err);
        check_value({31'd0, err}, 32'd0, "pslverr on mapped read");
        check_value(v, {21'd0, a}, "addr after unmapped writes");
        apb_read(REG_WDATA, v, err);
        check_value(v, 32'd0, "wdata after unmapped writes");
        apb_read(REG_STATUS, v, err);
        check_value(v, 32'h2, "status after unmapped writes");
        apb_read(REG_RDATA, v, err);
        check_value(v, {24'd0, last_rdata}, "rdata after unmapped writes");

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* filelist.f */
design/eeprom_pkg.sv
design/eeprom_regs.sv
design/eeprom_sequencer.sv
design/i2c_byte_engine.sv
design/eeprom_ctrl_top.sv
tests/clk_gen.sv
tests/eeprom_model.sv
tests/eeprom_ctrl_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module eeprom_ctrl_tb -f filelist.f -o eeprom_ctrl_sim
./obj_dir/eeprom_ctrl_sim
